/* hw/fcvt_pkg.sv */
// num_lanes must be a multiple of num_pes; the rounding mode comes with each request (no CSR)
package fcvt_pkg;

    // Lane and processing-element geometry
    localparam int num_lanes   = 4;
    localparam int num_pes     = 2;
    localparam int num_batches = num_lanes / num_pes;
    localparam int batch_w     = (num_batches > 1) ? $clog2(num_batches) : 1;

    // Register stages inside one PE (unpack, round/pack)
    localparam int pe_depth = 2;

    // Width of the transaction tag that travels with a request
    localparam int tag_w = 4;

    // RISC-V rounding-mode encoding
    typedef enum logic [2:0] {
        rm_rne = 3'd0,
        rm_rtz = 3'd1,
        rm_rdn = 3'd2,
        rm_rup = 3'd3,
        rm_rmm = 3'd4
    } frm_e;

    typedef enum logic [1:0] {
        op_itof_s = 2'd0,
        op_itof_u = 2'd1,
        op_ftoi_s = 2'd2,
        op_ftoi_u = 2'd3
    } cvt_op_e;

    // Exception flags in fflags CSR order
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        cvt_op_e                    op;
        frm_e                       frm;
        logic [num_lanes-1:0]       mask;
        logic [tag_w-1:0]           tag;
        logic [num_lanes-1:0][31:0] data;
    } cvt_req_t;

    // One operand as it enters a PE
    typedef struct packed {
        cvt_op_e     op;
        frm_e        frm;
        logic [31:0] operand;
    } pe_in_t;

    // Stage 1 to stage 2; the value is mag * 2^(exp-31)
    typedef struct packed {
        logic               sign;
        logic [31:0]        mag;
        logic signed [8:0]  exp;
        logic               is_zero;
        logic               is_inf;
        logic               is_nan;
        cvt_op_e            op;
        frm_e               frm;
    } unp_t;

    typedef struct packed {
        logic [31:0] data;
        fflags_t     flags;
    } pe_out_t;

    typedef struct packed {
        logic [num_lanes-1:0]    mask;
        logic [tag_w-1:0]        tag;
        pe_out_t [num_lanes-1:0] lanes;
    } cvt_rsp_t;

endpackage

/* hw/fcvt_lane_serializer.sv */
// Single response buffer; ready_in and pe_enable depend combinationally on ready_out
`timescale 1ns/1ps

module fcvt_lane_serializer (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  valid_in,
    output logic                                  ready_in,
    input  fcvt_pkg::cvt_req_t                    req,
    output logic                                  pe_enable,
    output fcvt_pkg::pe_in_t [fcvt_pkg::num_pes-1:0]  pe_data_out,
    input  fcvt_pkg::pe_out_t [fcvt_pkg::num_pes-1:0] pe_data_in,
    output logic                                  valid_out,
    input  logic                                  ready_out,
    output fcvt_pkg::cvt_rsp_t                    rsp
);
    import fcvt_pkg::*;

    // Bookkeeping that rides alongside each batch in the PE pipeline
    typedef struct packed {
        logic [batch_w-1:0]   batch;
        logic [num_lanes-1:0] mask;
        logic [tag_w-1:0]     tag;
    } slot_meta_t;

    cvt_req_t                req_q;
    logic                    busy;
    logic [batch_w-1:0]      batch_cnt;
    logic                    issue_last;
    logic                    accept;
    logic                    stall;

    logic [pe_depth-1:0]     slot_vld;
    logic [pe_depth-1:0]     slot_last;
    slot_meta_t [pe_depth-1:0] slot_meta;
    slot_meta_t              meta_new;

    pe_out_t [num_lanes-1:0] collect_q;
    pe_out_t [num_lanes-1:0] collect_d;
    logic                    ret_vld;
    logic                    out_wr;
    logic                    out_vld;
    cvt_rsp_t                rsp_q;

    assign issue_last = (batch_cnt == batch_w'(num_batches - 1));
    assign stall      = out_vld && !ready_out;

    // A new request may replace the held one while its last batch is issued
    assign ready_in  = !stall && (!busy || issue_last);
    assign accept    = valid_in && ready_in;
    assign pe_enable = !stall && (busy || (|slot_vld));

    always_comb begin
        for (int p = 0; p < num_pes; p++) begin
            pe_data_out[p].op      = req_q.op;
            pe_data_out[p].frm     = req_q.frm;
            pe_data_out[p].operand = req_q.data[int'(batch_cnt) * num_pes + p];
        end
    end

    assign meta_new.batch = batch_cnt;
    assign meta_new.mask  = req_q.mask;
    assign meta_new.tag   = req_q.tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            batch_cnt <= '0;
            slot_vld  <= '0;
            slot_last <= '0;
        end else begin
            if (pe_enable) begin
                slot_vld  <= {slot_vld[pe_depth-2:0], busy};
                slot_last <= {slot_last[pe_depth-2:0], issue_last};
                if (busy) begin
                    if (issue_last) begin
                        busy      <= 1'b0;
                        batch_cnt <= '0;
                    end else begin
                        batch_cnt <= batch_cnt + batch_w'(1);
                    end
                end
            end
            if (accept) begin
                busy      <= 1'b1;
                batch_cnt <= '0;
            end
        end
    end

    // The batch leaving the PEs this cycle is the oldest slot
    assign ret_vld = pe_enable && slot_vld[pe_depth-1];
    assign out_wr  = ret_vld && slot_last[pe_depth-1];

    always_comb begin
        collect_d = collect_q;
        for (int p = 0; p < num_pes; p++) begin
            collect_d[int'(slot_meta[pe_depth-1].batch) * num_pes + p] = pe_data_in[p];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (pe_enable) begin
            slot_meta <= {slot_meta[pe_depth-2:0], meta_new};
        end
        if (ret_vld) begin
            collect_q <= collect_d;
        end
        // Last batch goes straight from the PEs into the response buffer
        if (out_wr) begin
            rsp_q.mask  <= slot_meta[pe_depth-1].mask;
            rsp_q.tag   <= slot_meta[pe_depth-1].tag;
            rsp_q.lanes <= collect_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld <= 1'b0;
        end else if (out_wr) begin
            out_vld <= 1'b1;
        end else if (ready_out) begin
            out_vld <= 1'b0;
        end
    end

    assign valid_out = out_vld;
    assign rsp       = rsp_q;

    // A blocked response freezes the batch counter and the PE pipeline together
    a_frozen_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (out_vld && !ready_out) |=>
            ($stable(busy) && $stable(batch_cnt) && $stable(slot_vld)))
        else $error("PE pipeline advanced while the response buffer was blocked");

    a_rsp_held: assert property (@(posedge clk) disable iff (!arst_n)
        (out_vld && !ready_out) |=> (out_vld && $stable(rsp_q)))
        else $error("Response changed or dropped before it was consumed");

endmodule

/* hw/fcvt_unpack.sv */
// Subnormal floats are passed through unnormalized with exponent -126; holds when enable is low
`timescale 1ns/1ps

module fcvt_unpack (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             enable,
    input  fcvt_pkg::pe_in_t in,
    output fcvt_pkg::unp_t   out
);
    import fcvt_pkg::*;

    // Leading-zero count of a 32-bit word, 32 for zero
    function automatic logic [5:0] lzc32(input logic [31:0] v);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                n = 6'(31 - i);
            end
        end
        return n;
    endfunction

    logic        is_itof;
    logic        neg;
    logic [31:0] abs_val;
    logic [5:0]  lz;
    logic [7:0]  f_exp;
    logic [22:0] f_man;
    logic        f_sub;
    unp_t        unp_d;
    unp_t        unp_q;

    assign is_itof = (in.op == op_itof_s) || (in.op == op_itof_u);

    // Most negative int maps to 0x80000000, which is still the right magnitude
    assign neg     = (in.op == op_itof_s) && in.operand[31];
    assign abs_val = neg ? (~in.operand + 32'd1) : in.operand;
    assign lz      = lzc32(abs_val);

    assign f_exp = in.operand[30:23];
    assign f_man = in.operand[22:0];
    assign f_sub = (f_exp == 8'd0) && (f_man != 23'd0);

    always_comb begin
        unp_d.op  = in.op;
        unp_d.frm = in.frm;
        if (is_itof) begin
            unp_d.sign    = neg;
            unp_d.mag     = abs_val << lz;
            unp_d.exp     = 9'sd31 - $signed({3'b000, lz});
            unp_d.is_zero = (abs_val == 32'd0);
            unp_d.is_inf  = 1'b0;
            unp_d.is_nan  = 1'b0;
        end else begin
            unp_d.sign = in.operand[31];
            // Hidden bit lands on bit 31 so both paths share one alignment
            unp_d.mag  = {(f_exp != 8'd0), f_man, 8'd0};
            if (f_sub) begin
                unp_d.exp = -9'sd126;
            end else begin
                unp_d.exp = $signed({1'b0, f_exp}) - 9'sd127;
            end
            unp_d.is_zero = (f_exp == 8'd0) && (f_man == 23'd0);
            unp_d.is_inf  = (f_exp == 8'hff) && (f_man == 23'd0);
            unp_d.is_nan  = (f_exp == 8'hff) && (f_man != 23'd0);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unp_q <= '0;
        end else if (enable) begin
            unp_q <= unp_d;
        end
    end

    assign out = unp_q;

    a_legal_frm: assert property (@(posedge clk) disable iff (!arst_n)
        enable |-> (in.frm inside {rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm}))
        else $error("Illegal rounding mode issued to a PE");

endmodule

/* hw/fcvt_round_pack.sv */
// Invalid conversions raise nv only; dz, of and uf are never set by these conversions
`timescale 1ns/1ps

module fcvt_round_pack (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              enable,
    input  fcvt_pkg::unp_t    in,
    output fcvt_pkg::pe_out_t out
);
    import fcvt_pkg::*;

    // Round-increment decision from the kept LSB, guard and sticky bits
    function automatic logic round_up(input frm_e rm, input logic sign,
                                      input logic lsb, input logic g, input logic s);
        case (rm)
            rm_rne:  return g && (s || lsb);
            rm_rtz:  return 1'b0;
            rm_rdn:  return sign && (g || s);
            rm_rup:  return !sign && (g || s);
            rm_rmm:  return g;
            default: return 1'b0;
        endcase
    endfunction

    logic        is_itof;
    logic        signed_op;

    // Integer to float
    logic        if_g;
    logic        if_s;
    logic [24:0] if_mant;
    logic [8:0]  if_bexp;
    pe_out_t     if_res;

    // Float to integer
    logic [5:0]  sh;
    logic [31:0] int_p;
    logic [31:0] frac;
    logic        fi_g;
    logic        fi_s;
    logic        ovf_exp;
    logic [32:0] int_r;
    logic [31:0] sat_pos;
    logic [31:0] sat_neg;
    pe_out_t     fi_res;

    pe_out_t     res_q;

    assign is_itof   = (in.op == op_itof_s) || (in.op == op_itof_u);
    assign signed_op = (in.op == op_ftoi_s);

    assign if_g    = in.mag[7];
    assign if_s    = |in.mag[6:0];
    assign if_mant = {1'b0, in.mag[31:8]} +
                     25'(round_up(in.frm, in.sign, in.mag[8], if_g, if_s));
    // A carry out of the mantissa leaves the fraction bits at zero
    assign if_bexp = 9'(in.exp + 9'sd127) + {8'd0, if_mant[24]};

    always_comb begin
        if_res.flags    = '0;
        if_res.flags.nx = if_g || if_s;
        if (in.is_zero) begin
            if_res.data = 32'd0;
        end else begin
            if_res.data = {in.sign, if_bexp[7:0], if_mant[22:0]};
        end
    end

    assign sh = 6'(in.exp + 9'sd1);

    // Split mag * 2^(exp-31) into integer part and fraction
    always_comb begin
        int_p   = '0;
        frac    = '0;
        fi_g    = 1'b0;
        fi_s    = 1'b0;
        ovf_exp = 1'b0;
        if (in.exp > 9'sd31) begin
            ovf_exp = 1'b1;
        end else if (in.exp < -9'sd1) begin
            fi_s = |in.mag;
        end else begin
            {int_p, frac} = {32'd0, in.mag} << sh;
            fi_g = frac[31];
            fi_s = |frac[30:0];
        end
    end

    assign int_r   = {1'b0, int_p} + 33'(round_up(in.frm, in.sign, int_p[0], fi_g, fi_s));
    assign sat_pos = signed_op ? 32'h7fff_ffff : 32'hffff_ffff;
    assign sat_neg = signed_op ? 32'h8000_0000 : 32'h0000_0000;

    always_comb begin
        fi_res.flags = '0;
        fi_res.data  = '0;
        if (in.is_nan) begin
            fi_res.data     = sat_pos;
            fi_res.flags.nv = 1'b1;
        end else if (in.is_inf || ovf_exp) begin
            fi_res.data     = in.sign ? sat_neg : sat_pos;
            fi_res.flags.nv = 1'b1;
        end else if (signed_op) begin
            if (!in.sign && (int_r[32] || int_r[31])) begin
                fi_res.data     = sat_pos;
                fi_res.flags.nv = 1'b1;
            end else if (in.sign && (int_r[32] || (int_r[31] && (|int_r[30:0])))) begin
                fi_res.data     = sat_neg;
                fi_res.flags.nv = 1'b1;
            end else begin
                fi_res.data     = in.sign ? (~int_r[31:0] + 32'd1) : int_r[31:0];
                fi_res.flags.nx = fi_g || fi_s;
            end
        end else begin
            if (!in.sign && int_r[32]) begin
                fi_res.data     = sat_pos;
                fi_res.flags.nv = 1'b1;
            end else if (in.sign && (int_r != 33'd0)) begin
                fi_res.data     = 32'd0;
                fi_res.flags.nv = 1'b1;
            end else begin
                // Negative inputs that round to zero land here with only nx
                fi_res.data     = in.sign ? 32'd0 : int_r[31:0];
                fi_res.flags.nx = fi_g || fi_s;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_q <= '0;
        end else if (enable) begin
            res_q <= is_itof ? if_res : fi_res;
        end
    end

    assign out = res_q;

endmodule

/* hw/fcvt_cvt.sv */
// Responses leave in acceptance order; fflags merges only lanes set in the returned mask
`timescale 1ns/1ps

module fcvt_cvt (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   valid_in,
    output logic                                   ready_in,
    input  fcvt_pkg::cvt_req_t                     req,
    output logic                                   valid_out,
    input  logic                                   ready_out,
    output logic [fcvt_pkg::num_lanes-1:0][31:0]   result,
    output fcvt_pkg::fflags_t                      fflags,
    output logic [fcvt_pkg::tag_w-1:0]             tag_out
);
    import fcvt_pkg::*;

    logic                  pe_enable;
    pe_in_t  [num_pes-1:0] pe_in;
    unp_t    [num_pes-1:0] pe_unp;
    pe_out_t [num_pes-1:0] pe_out;
    cvt_rsp_t              rsp;
    logic [4:0]            flag_acc;

    fcvt_lane_serializer serializer0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .valid_in    (valid_in),
        .ready_in    (ready_in),
        .req         (req),
        .pe_enable   (pe_enable),
        .pe_data_out (pe_in),
        .pe_data_in  (pe_out),
        .valid_out   (valid_out),
        .ready_out   (ready_out),
        .rsp         (rsp)
    );

    for (genvar i = 0; i < num_pes; i++) begin : g_pe
        fcvt_unpack unpack0 (
            .clk    (clk),
            .arst_n (arst_n),
            .enable (pe_enable),
            .in     (pe_in[i]),
            .out    (pe_unp[i])
        );

        fcvt_round_pack round0 (
            .clk    (clk),
            .arst_n (arst_n),
            .enable (pe_enable),
            .in     (pe_unp[i]),
            .out    (pe_out[i])
        );
    end

    // Inactive lanes still carry flags from whatever operand they held
    always_comb begin
        flag_acc = '0;
        for (int i = 0; i < num_lanes; i++) begin
            result[i] = rsp.lanes[i].data;
            if (rsp.mask[i]) begin
                flag_acc = flag_acc | rsp.lanes[i].flags;
            end
        end
    end

    assign fflags  = fflags_t'(flag_acc);
    assign tag_out = rsp.tag;

endmodule

/* verification/fcvt_cvt_tb.sv */
// Run from the project root so the trace path resolves; the trace must hold exactly num_vec rows
`timescale 1ns/1ps

module fcvt_cvt_tb;
    import fcvt_pkg::*;

    localparam int num_vec     = 22;
    localparam int vec_words   = 13;
    localparam int clk_period  = 40;
    localparam int watchdog_ns = (num_vec * 40 + 200) * clk_period;

    logic                       clk;
    logic                       arst_n;
    logic                       valid_in;
    logic                       ready_in;
    cvt_req_t                   req;
    logic                       valid_out;
    logic                       ready_out;
    logic [num_lanes-1:0][31:0] result;
    fflags_t                    fflags;
    logic [tag_w-1:0]           tag_out;

    // Row layout: op frm mask tag, four operands, four expected lanes, merged flags
    logic [31:0] trace_mem [0:num_vec*vec_words-1];
    logic [31:0] lfsr_state;
    int          exp_q[$];
    int          error_count;
    int          tests_run;
    int          tests_passed;

    logic [num_lanes-1:0][31:0] held_result;
    fflags_t                    held_flags;
    logic [tag_w-1:0]           held_tag;
    logic                       held_pending;

    fcvt_cvt dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .req       (req),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic load_request(input int idx);
        int base;
        base = idx * vec_words;
        req.op   = cvt_op_e'(trace_mem[base][1:0]);
        req.frm  = frm_e'(trace_mem[base+1][2:0]);
        req.mask = trace_mem[base+2][num_lanes-1:0];
        req.tag  = trace_mem[base+3][tag_w-1:0];
        for (int l = 0; l < num_lanes; l++) begin
            req.data[l] = trace_mem[base+4+l];
        end
    endtask

    task automatic check_response(input int idx);
        int         base;
        int         errs;
        logic [4:0] got_flags;
        logic [4:0] exp_flags;
        base      = idx * vec_words;
        errs      = 0;
        got_flags = fflags;
        exp_flags = trace_mem[base+12][4:0];
        if (tag_out != trace_mem[base+3][tag_w-1:0]) begin
            $display("[ERROR] vector %0d tag_out: got %h expected %h",
                     idx, tag_out, trace_mem[base+3][tag_w-1:0]);
            errs++;
        end
        // Lanes outside the mask carry no defined result
        for (int l = 0; l < num_lanes; l++) begin
            if (trace_mem[base+2][l] && (result[l] != trace_mem[base+8+l])) begin
                $display("[ERROR] vector %0d result[%0d]: got %h expected %h",
                         idx, l, result[l], trace_mem[base+8+l]);
                errs++;
            end
        end
        if (got_flags != exp_flags) begin
            $display("[ERROR] vector %0d fflags: got %h expected %h", idx, got_flags, exp_flags);
            errs++;
        end
        tests_run++;
        if (errs == 0) begin
            tests_passed++;
            $display("vector %0d (tag %h): ok", idx, tag_out);
        end else begin
            error_count += errs;
            $display("vector %0d (tag %h): %0d mismatches", idx, tag_out, errs);
        end
    endtask

    task automatic check_hold();
        if (!valid_out) begin
            $display("A stalled response was withdrawn before ready_out was high");
            error_count++;
        end else begin
            if (result != held_result) begin
                $display("[ERROR] held result changed: %h -> %h", held_result, result);
                error_count++;
            end
            if (fflags != held_flags) begin
                $display("[ERROR] held fflags changed: %h -> %h", held_flags, fflags);
                error_count++;
            end
            if (tag_out != held_tag) begin
                $display("[ERROR] held tag_out changed: %h -> %h", held_tag, tag_out);
                error_count++;
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0] bits;
        int          next_idx;
        int          gap_left;
        int          done_count;
        logic        in_fire;
        logic        out_fire;
        arst_n       = 1'b0;
        valid_in     = 1'b0;
        ready_out    = 1'b0;
        req          = '0;
        lfsr_state   = 32'he046_602a;
        error_count  = 0;
        tests_run    = 0;
        tests_passed = 0;
        held_pending = 1'b0;
        held_result  = '0;
        held_flags   = '0;
        held_tag     = '0;
        next_idx     = 0;
        gap_left     = 0;
        done_count   = 0;
        in_fire      = 1'b0;
        $readmemh("verification/fcvt_trace.txt", trace_mem);
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // Out of reset the unit is idle and takes a request at once
        if (!ready_in || valid_out) begin
            $display("[ERROR] after reset ready_in %h valid_out %h, expected 1 and 0",
                     ready_in, valid_out);
            error_count++;
        end
        while (done_count < num_vec) begin
            @(negedge clk);
            take_bits(2, bits);
            ready_out = (bits[1:0] != 2'b00);
            if (in_fire) begin
                valid_in = 1'b0;
                next_idx++;
                take_bits(2, bits);
                gap_left = bits[1] ? int'(bits[0]) + 1 : 0;
            end
            if (!valid_in && next_idx < num_vec) begin
                if (gap_left == 0) begin
                    load_request(next_idx);
                    valid_in = 1'b1;
                end else begin
                    gap_left--;
                end
            end
            // Inputs are settled now and nothing changes until the next rising edge
            #1;
            in_fire  = valid_in && ready_in;
            out_fire = valid_out && ready_out;
            if (held_pending) begin
                check_hold();
            end
            if (out_fire) begin
                if (exp_q.size() == 0) begin
                    $display("A response arrived with no request outstanding");
                    error_count++;
                end else begin
                    check_response(exp_q.pop_front());
                    done_count++;
                end
            end
            held_pending = valid_out && !ready_out;
            held_result  = result;
            held_flags   = fflags;
            held_tag     = tag_out;
            if (in_fire) begin
                exp_q.push_back(next_idx);
            end
        end
        valid_in  = 1'b0;
        ready_out = 1'b1;
        repeat (4) @(negedge clk);
        #1;
        if (valid_out || exp_q.size() != 0) begin
            $display("A response appeared after the last expected one");
            error_count++;
        end
        $display("tests: %0d run, %0d passed, %0d errors", tests_run, tests_passed, error_count);
        if (error_count == 0 && tests_passed == num_vec) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: not all responses arrived within %0d ns", watchdog_ns);
        $display("sim failed");
        $finish;
    end

endmodule

/* verification/fcvt_trace.txt */
// op frm mask tag, operand lane0..lane3, expected lane0..lane3, merged fflags (nv dz of uf nx)
// op 0 itof_s, 1 itof_u, 2 ftoi_s, 3 ftoi_u; frm 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm
0 0 f 1 00000000 00000001 ffffffff 80000000 00000000 3f800000 bf800000 cf000000 00
0 0 f 2 01000001 01000003 7fffffff feffffff 4b800000 4b800002 4f000000 cb800000 01
0 1 f 3 01000001 01000003 7fffffff feffffff 4b800000 4b800001 4effffff cb800000 01
0 2 f 4 01000001 01000003 7fffffff feffffff 4b800000 4b800001 4effffff cb800001 01
0 3 f 5 01000001 01000003 7fffffff feffffff 4b800001 4b800002 4f000000 cb800000 01
0 4 f 6 01000001 01000003 7fffffff feffffff 4b800001 4b800002 4f000000 cb800001 01
1 0 f 7 ffffffff 80000000 00000003 00000000 4f800000 4f000000 40400000 00000000 01
1 1 f 8 ffffffff 80000001 00000005 12345678 4f7fffff 4f000000 40a00000 4d91a2b3 01
2 0 f 9 3fc00000 40200000 bfc00000 c0200000 00000002 00000002 fffffffe fffffffe 01
2 4 f a 3fc00000 40200000 bfc00000 c0200000 00000002 00000003 fffffffe fffffffd 01
2 2 f b 3fc00000 be800000 3e800000 c0200000 00000001 ffffffff 00000000 fffffffd 01
2 3 f c 3fc00000 be800000 3e800000 c0200000 00000002 00000000 00000001 fffffffe 01
3 3 f d be800000 3f000000 3f800000 42f60000 00000000 00000001 00000001 0000007b 01
3 1 f e bf000000 40700000 00000000 80000000 00000000 00000003 00000000 00000000 01
2 1 f f 7f800000 ff800000 7fc00000 4f000000 7fffffff 80000000 7fffffff 7fffffff 10
3 0 f 0 bf800000 4f800000 ffc00000 4f7fffff 00000000 ffffffff ffffffff ffffff00 10
2 0 f 1 cf000000 cf000001 4effffff 501502f9 80000000 80000000 7fffff80 7fffffff 10
0 0 5 2 00000002 01000001 fffffffe 7fffffff 40000000 00000000 c0000000 00000000 00
2 1 a 3 7fc00000 41200000 7f800000 c1200000 00000000 0000000a 00000000 fffffff6 00
3 1 8 4 7fc00000 7fc00000 7fc00000 3fc00000 00000000 00000000 00000000 00000001 01
1 3 1 5 01000001 00000000 00000000 00000000 4b800001 00000000 00000000 00000000 01
2 4 f 6 3f000000 bf000000 3f800000 501502f9 00000001 ffffffff 00000001 7fffffff 11

/* fcvt_cvt.f */
hw/fcvt_pkg.sv
hw/fcvt_lane_serializer.sv
hw/fcvt_unpack.sv
hw/fcvt_round_pack.sv
hw/fcvt_cvt.sv
verification/fcvt_cvt_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the conversion unit testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module fcvt_cvt_tb -f fcvt_cvt.f -o fcvt_sim

./obj_dir/fcvt_sim | tee sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
else
    exit 1
fi
